//--- rtl/sepr_pkg.sv
package sepr_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------

   // Local buffer addresses, endpoint pointers and the system address
   localparam int unsigned addr_w = 32;

   // DMA transfer length in bytes
   localparam int unsigned len_w = 20;

   // ------------------------------------------------------------------------
   // Buffer constants
   // ------------------------------------------------------------------------

   // Read pointer step past one header word
   localparam int unsigned word_bytes = 4;

   // Last-operation flag value for a read
   localparam logic last_op_read = 1'b0;

   // ------------------------------------------------------------------------
   // Sequencer states
   // ------------------------------------------------------------------------

   // One command in flight at a time.
   // Every state except idle finishes back in idle.
   typedef enum logic [2:0] {
      st_idle    = 3'b000,    // Waiting for a command strobe
      st_rd_ptr  = 3'b001,    // Attributes loaded, report back
      st_rd_hdr  = 3'b010,    // Header word read in flight
      st_rd_data = 3'b011,    // DMA transfer running
      st_updt    = 3'b100     // Read pointer write-back
   } sepr_state_t;

   // Encodings 101 to 111 are unused.
   // The sequencer falls back to idle if it ever lands on one.
   // Widths above are shared by all the RTL blocks and the checker.
   // The header word low two bits give the byte offset of the packet end.
   // The length math assumes word_bytes is four.
   // The system write address always moves in whole words.
   // The length itself can still end mid-word.
   // Only the low len_w bits of the length leave the block.

endpackage

//--- rtl/sepr_ctrl_fsm.sv
module sepr_ctrl_fsm
   import sepr_pkg::*;
(
   input  logic core_clk,
   input  logic uctl_rst_n,
   input  logic get_rd_ptrs,      // Fetch endpoint attributes
   input  logic wr_addr_en,       // Reload system write address with the fetch
   input  logic hdr_rd,           // Read packet header word
   input  logic rd,               // Start DMA transfer
   input  logic updt_rd_buf,      // Write back read pointer, level
   input  logic mem_ack,
   input  logic dma_dn,
   input  logic ept_updt_dn,
   input  logic buf_empty_in,     // Emptiness from the pointer block
   output logic rd_ptrs_rcvd,
   output logic buf_empty,
   output logic hdr_rd_dn,
   output logic transfer_dn,
   output logic buf_updt_dn,
   output logic mem_rd,
   output logic dma_start,
   output logic ept_req_data,
   output logic ept_updt_req,
   output logic ld_ptr,           // Load attributes into pointer block
   output logic ld_hdr,           // Advance read pointer
   output logic wr_addr_load,     // Load system write address
   output logic xfer_done         // Advance system write address
);

   sepr_state_t state;
   sepr_state_t state_nxt;
   logic        mem_rd_nxt;
   logic        dma_start_nxt;
   logic        ept_updt_req_nxt;
   logic        buf_updt_dn_nxt;
   logic        dma_dn_q;         // DMA done, one cycle late

   // ------------------------------------------------------------------------
   // Next state and strobe decode
   // ------------------------------------------------------------------------
   always_comb begin
      state_nxt        = state;
      mem_rd_nxt       = mem_rd;          // Held until ack
      dma_start_nxt    = 1'b0;            // Single cycle pulse
      ept_updt_req_nxt = ept_updt_req;    // Held until done
      buf_updt_dn_nxt  = 1'b0;
      rd_ptrs_rcvd     = 1'b0;
      buf_empty        = 1'b0;
      hdr_rd_dn        = 1'b0;
      transfer_dn      = 1'b0;
      ept_req_data     = 1'b0;
      ld_ptr           = 1'b0;
      ld_hdr           = 1'b0;
      wr_addr_load     = 1'b0;
      xfer_done        = 1'b0;

      case (state)
         st_idle: begin
            if (get_rd_ptrs) begin
               ept_req_data = 1'b1;        // Same cycle as the strobe
               ld_ptr       = 1'b1;
               wr_addr_load = wr_addr_en;
               state_nxt    = st_rd_ptr;
            end else if (hdr_rd) begin
               mem_rd_nxt = 1'b1;
               state_nxt  = st_rd_hdr;
            end else if (rd) begin
               dma_start_nxt = 1'b1;
               state_nxt     = st_rd_data;
            end else if (updt_rd_buf) begin
               ept_updt_req_nxt = 1'b1;
               state_nxt        = st_updt;
            end
         end

         st_rd_ptr: begin
            rd_ptrs_rcvd = 1'b1;
            buf_empty    = buf_empty_in;    // Valid only with rd_ptrs_rcvd
            state_nxt    = st_idle;
         end

         st_rd_hdr: begin
            if (mem_ack) begin
               mem_rd_nxt = 1'b0;
               ld_hdr     = 1'b1;           // Pointer steps at end of ack cycle
               hdr_rd_dn  = 1'b1;
               state_nxt  = st_idle;
            end
         end

         st_rd_data: begin
            if (dma_dn_q) begin
               transfer_dn = 1'b1;
               xfer_done   = 1'b1;
               state_nxt   = st_idle;
            end
         end

         st_updt: begin
            if (ept_updt_dn) begin
               ept_updt_req_nxt = 1'b0;
               buf_updt_dn_nxt  = 1'b1;
            end
            if (!updt_rd_buf) state_nxt = st_idle;   // Leave once the level drops
         end

         default: state_nxt = st_idle;
      endcase
   end

   // ------------------------------------------------------------------------
   // State and registered outputs
   // ------------------------------------------------------------------------
   always_ff @(posedge core_clk or negedge uctl_rst_n) begin
      if (!uctl_rst_n) begin
         state        <= st_idle;
         mem_rd       <= 1'b0;
         dma_start    <= 1'b0;
         ept_updt_req <= 1'b0;
         buf_updt_dn  <= 1'b0;    // Registered update done
         dma_dn_q     <= 1'b0;    // Registered DMA done
      end else begin
         state        <= state_nxt;
         mem_rd       <= mem_rd_nxt;
         dma_start    <= dma_start_nxt;
         ept_updt_req <= ept_updt_req_nxt;
         buf_updt_dn  <= buf_updt_dn_nxt;
         dma_dn_q     <= dma_dn;
      end
   end

   a_state_onehot: assert property (@(posedge core_clk) disable iff (!uctl_rst_n)
      $onehot({state == st_idle, state == st_rd_ptr, state == st_rd_hdr,
               state == st_rd_data, state == st_updt}))
      else $error("sequencer state not one of the five legal states");

   a_dma_start_pulse: assert property (@(posedge core_clk) disable iff (!uctl_rst_n)
      dma_start |=> !dma_start)
      else $error("dma_start held for two cycles");

endmodule

//--- rtl/sepr_ptr_regs.sv
module sepr_ptr_regs
   import sepr_pkg::*;
(
   input  logic              core_clk,
   input  logic              uctl_rst_n,
   input  logic              ld_ptr,          // Register endpoint attributes
   input  logic              ld_hdr,          // Step read pointer past header
   input  logic [addr_w-1:0] ept_start_addr,
   input  logic [addr_w-1:0] ept_end_addr,
   input  logic [addr_w-1:0] ept_rd_ptr,
   input  logic [addr_w-1:0] ept_wr_ptr,
   input  logic              ept_last_op,
   input  logic [addr_w-1:0] mem_rd_data,     // Header word from buffer memory
   input  logic              mem_dval,
   output logic [addr_w-1:0] start_addr,
   output logic [addr_w-1:0] end_addr,
   output logic [addr_w-1:0] rd_ptr,
   output logic [addr_w-1:0] next_rd_ptr,     // Captured header word
   output logic              buf_empty
);

   logic [addr_w-1:0] wr_ptr;
   logic              last_op;

   // ------------------------------------------------------------------------
   // Endpoint attributes
   // ------------------------------------------------------------------------
   always_ff @(posedge core_clk or negedge uctl_rst_n) begin
      if (!uctl_rst_n) begin
         start_addr <= '0;
         end_addr   <= '0;
         wr_ptr     <= '0;
         last_op    <= 1'b0;
      end else if (ld_ptr) begin
         start_addr <= ept_start_addr;
         end_addr   <= ept_end_addr;
         wr_ptr     <= ept_wr_ptr;
         last_op    <= ept_last_op;
      end
   end

   // Read pointer, loaded on fetch and stepped after the header read
   always_ff @(posedge core_clk or negedge uctl_rst_n) begin
      if (!uctl_rst_n) begin
         rd_ptr <= '0;
      end else if (ld_ptr) begin
         rd_ptr <= ept_rd_ptr;
      end else if (ld_hdr) begin
         if (rd_ptr > end_addr)
            rd_ptr <= start_addr;                   // Wrap past buffer end
         else
            rd_ptr <= rd_ptr + addr_w'(word_bytes); // Next word
      end
   end

   // Header word holds the next read pointer
   always_ff @(posedge core_clk) begin
      if (mem_dval) next_rd_ptr <= mem_rd_data;    // Every valid beat
   end

   // Pointers meet after a read, so nothing left to send
   assign buf_empty = (wr_ptr == rd_ptr) && (last_op == last_op_read);

   a_ld_excl: assert property (@(posedge core_clk) disable iff (!uctl_rst_n)
      !(ld_ptr && ld_hdr))
      else $error("attribute load and header advance in the same cycle");

endmodule

//--- rtl/sepr_xfer_calc.sv
module sepr_xfer_calc
   import sepr_pkg::*;
(
   input  logic              core_clk,
   input  logic              uctl_rst_n,
   input  logic              wr_addr_load,     // Restart system address
   input  logic              xfer_done,        // Transfer finished, step address
   input  logic [addr_w-1:0] start_addr,
   input  logic [addr_w-1:0] end_addr,
   input  logic [addr_w-1:0] rd_ptr,
   input  logic [addr_w-1:0] next_rd_ptr,      // Header word
   input  logic [addr_w-1:0] cfg_sys_wr_addr,
   output logic [len_w-1:0]  dma_len,
   output logic [addr_w-1:0] sys_wr_addr
);

   logic [addr_w-1:0] hdr_word;      // Header word, word aligned
   logic [1:0]        hdr_lsb;       // Byte offset inside last word
   logic [addr_w-1:0] pad;           // Unused bytes of last word
   logic [addr_w-1:0] xfer_len;
   logic [addr_w-1:0] xfer_len_rnd;  // Length in whole words

   // ------------------------------------------------------------------------
   // Transfer length
   // ------------------------------------------------------------------------
   assign hdr_word = {next_rd_ptr[addr_w-1:2], 2'b00};
   assign hdr_lsb  = next_rd_ptr[1:0];
   assign pad      = (hdr_lsb == 2'b00) ? '0
                   : addr_w'(word_bytes) - addr_w'(hdr_lsb);

   always_comb begin
      if (rd_ptr <= next_rd_ptr) begin
         // Packet sits in one piece
         xfer_len = hdr_word - rd_ptr - pad;
      end else begin
         // Tail up to the buffer end, then from the start again
         xfer_len = (end_addr + addr_w'(word_bytes) - rd_ptr)
                  + (hdr_word - start_addr) - pad;
      end
   end

   assign dma_len = xfer_len[len_w-1:0];

   // Round a partial word up to the next whole one
   assign xfer_len_rnd = {xfer_len[addr_w-1:2], 2'b00}
                       + ((xfer_len[1:0] != 2'b00) ? addr_w'(word_bytes) : '0);

   // ------------------------------------------------------------------------
   // System write address
   // ------------------------------------------------------------------------
   always_ff @(posedge core_clk or negedge uctl_rst_n) begin
      if (!uctl_rst_n) begin
         sys_wr_addr <= '0;
      end else if (wr_addr_load) begin
         sys_wr_addr <= cfg_sys_wr_addr;              // Fresh base from config
      end else if (xfer_done) begin
         sys_wr_addr <= sys_wr_addr + xfer_len_rnd;   // Word granular
      end
   end

endmodule

//--- rtl/sepr_top.sv
module sepr_top
   import sepr_pkg::*;
(
   input  logic              core_clk,
   input  logic              uctl_rst_n,
   // System controller commands and status
   input  logic              get_rd_ptrs,
   input  logic              wr_addr_en,
   input  logic              hdr_rd,
   input  logic              rd,
   input  logic              updt_rd_buf,
   output logic              rd_ptrs_rcvd,
   output logic              buf_empty,
   output logic              hdr_rd_dn,
   output logic              transfer_dn,
   output logic              buf_updt_dn,
   // Buffer memory
   input  logic [addr_w-1:0] mem_rd_data,
   input  logic              mem_ack,
   input  logic              mem_dval,
   output logic [addr_w-1:0] mem_addr,
   output logic              mem_rd,
   // DMA
   input  logic              dma_dn,
   input  logic [addr_w-1:0] cfg_sys_wr_addr,
   output logic              dma_start,
   output logic [addr_w-1:0] dma_laddr,
   output logic [len_w-1:0]  dma_len,
   output logic [addr_w-1:0] dma_ep_start_addr,
   output logic [addr_w-1:0] dma_ep_end_addr,
   output logic [addr_w-1:0] sys_wr_addr,
   // Endpoint store
   input  logic [addr_w-1:0] ept_start_addr,
   input  logic [addr_w-1:0] ept_end_addr,
   input  logic [addr_w-1:0] ept_rd_ptr,
   input  logic [addr_w-1:0] ept_wr_ptr,
   input  logic              ept_last_op,
   input  logic              ept_updt_dn,
   output logic              ept_req_data,
   output logic              ept_updt_req,
   output logic [addr_w-1:0] ept_wr_rd_ptr
);

   logic              ld_ptr;
   logic              ld_hdr;
   logic              wr_addr_load;
   logic              xfer_done;
   logic              ptr_buf_empty;   // Raw emptiness, before the FSM gates it
   logic [addr_w-1:0] start_addr;
   logic [addr_w-1:0] end_addr;
   logic [addr_w-1:0] rd_ptr;
   logic [addr_w-1:0] next_rd_ptr;

   sepr_ctrl_fsm i_ctrl_fsm (
      .core_clk, .uctl_rst_n, .get_rd_ptrs, .wr_addr_en, .hdr_rd, .rd, .updt_rd_buf,
      .mem_ack, .dma_dn, .ept_updt_dn, .buf_empty_in(ptr_buf_empty),
      .rd_ptrs_rcvd, .buf_empty, .hdr_rd_dn, .transfer_dn, .buf_updt_dn,
      .mem_rd, .dma_start, .ept_req_data, .ept_updt_req,
      .ld_ptr, .ld_hdr, .wr_addr_load, .xfer_done
   );

   sepr_ptr_regs i_ptr_regs (
      .core_clk, .uctl_rst_n, .ld_ptr, .ld_hdr,
      .ept_start_addr, .ept_end_addr, .ept_rd_ptr, .ept_wr_ptr, .ept_last_op,
      .mem_rd_data, .mem_dval,
      .start_addr, .end_addr, .rd_ptr, .next_rd_ptr, .buf_empty(ptr_buf_empty)
   );

   sepr_xfer_calc i_xfer_calc (
      .core_clk, .uctl_rst_n, .wr_addr_load, .xfer_done,
      .start_addr, .end_addr, .rd_ptr, .next_rd_ptr, .cfg_sys_wr_addr,
      .dma_len, .sys_wr_addr
   );

   assign mem_addr          = rd_ptr;    // Header read address
   assign dma_laddr         = rd_ptr;    // Payload starts after the header
   assign dma_ep_start_addr = start_addr;
   assign dma_ep_end_addr   = end_addr;
   assign ept_wr_rd_ptr     = {next_rd_ptr[addr_w-1:2], 2'b00};   // Word aligned write-back

endmodule

//--- verif/sepr_checker.sv
module sepr_checker
   import sepr_pkg::*;
(
   input  logic              core_clk,
   input  logic              uctl_rst_n,
   input  logic              get_rd_ptrs, wr_addr_en, hdr_rd, rd, updt_rd_buf,
   input  logic              mem_ack, dma_dn, ept_updt_dn,
   input  logic              rd_ptrs_rcvd, buf_empty, hdr_rd_dn, transfer_dn, buf_updt_dn,
   input  logic              mem_rd, dma_start, ept_req_data, ept_updt_req,
   input  logic [addr_w-1:0] mem_addr, dma_laddr, sys_wr_addr, ept_wr_rd_ptr,
   input  logic [addr_w-1:0] dma_ep_start_addr, dma_ep_end_addr,
   input  logic [len_w-1:0]  dma_len,
   input  int                row_idx,          // Scenario in flight
   input  logic [addr_w-1:0] row_start, row_end, row_rd_ptr, row_wr_ptr, row_hdr, row_cfg,
   input  logic              row_last_op, row_exp_empty,
   input  logic [len_w-1:0]  row_exp_len,      // Hand-worked length from the table
   input  logic              run_done,
   output int                err_cnt
);

   int                value_errs = 0;
   int                pulse_errs = 0;
   int                n_checks   = 0;
   logic              fetch_q    = 1'b0;       // Command seen one cycle back
   logic              hdr_q      = 1'b0;
   logic              ack_q      = 1'b0;
   logic              rd_q       = 1'b0;
   logic              dma_dn_q   = 1'b0;
   logic              xfer_q     = 1'b0;
   logic              updt_q     = 1'b0;       // Update request must be held
   logic              updt_dn_q  = 1'b0;
   logic              lvl_q      = 1'b0;       // Previous updt_rd_buf level
   logic              reported   = 1'b0;
   logic              exp_empty;
   logic [addr_w-1:0] exp_adv;                 // Read pointer after the header
   logic [addr_w-1:0] hdr_w;
   logic [addr_w-1:0] pad;
   logic [addr_w-1:0] exp_len;
   logic [addr_w-1:0] exp_sys;                 // System write address model

   // ------------------------------------------------------------------------
   // Reference values for the current row
   // ------------------------------------------------------------------------
   always_comb begin
      exp_empty = (row_wr_ptr == row_rd_ptr) && (row_last_op == 1'b0);
      exp_adv   = (row_rd_ptr > row_end) ? row_start : row_rd_ptr + 32'd4;
      hdr_w     = row_hdr & ~32'd3;
      pad       = (row_hdr[1:0] == 2'b00) ? 32'd0 : 32'd4 - {30'd0, row_hdr[1:0]};
      if (exp_adv <= row_hdr)
         exp_len = hdr_w - exp_adv - pad;                       // One piece
      else
         exp_len = (row_end + 32'd4 - exp_adv) + (hdr_w - row_start) - pad;
   end

   task automatic check_val(input string what, input logic [addr_w-1:0] exp_v,
                            input logic [addr_w-1:0] act_v);
      n_checks++;
      if (act_v !== exp_v) begin
         value_errs++;
         $display("Fail %s row %0d: expected %h, actual %h", what, row_idx, exp_v, act_v);
      end
   endtask

   task automatic need_pulse(input logic seen, input string what);
      n_checks++;
      if (!seen) begin
         pulse_errs++;
         $display("Row %0d: %s", row_idx, what);
      end
   endtask

   // ------------------------------------------------------------------------
   // Port watch on the rising edge
   // ------------------------------------------------------------------------
   always @(posedge core_clk) begin
      if (!uctl_rst_n) begin
         check_val("reset controls", '0, addr_w'({mem_rd, dma_start, ept_req_data,
                   ept_updt_req, rd_ptrs_rcvd, buf_empty, hdr_rd_dn, transfer_dn,
                   buf_updt_dn}));
         exp_sys <= '0;
      end else begin
         if (get_rd_ptrs) begin
            need_pulse(ept_req_data, "no ept_req_data alongside get_rd_ptrs");
            if (wr_addr_en) exp_sys <= row_cfg;                 // Restart from config
         end
         if (fetch_q) begin
            need_pulse(rd_ptrs_rcvd, "no rd_ptrs_rcvd one cycle after get_rd_ptrs");
            check_val("table buf_empty", addr_w'(row_exp_empty), addr_w'(exp_empty));
            check_val("buf_empty", addr_w'(exp_empty), addr_w'(buf_empty));
            check_val("sys_wr_addr after fetch", exp_sys, sys_wr_addr);
            check_val("dma_ep_start_addr", row_start, dma_ep_start_addr);
            check_val("dma_ep_end_addr", row_end, dma_ep_end_addr);
         end
         if (hdr_q) need_pulse(mem_rd, "mem_rd did not rise after hdr_rd");
         if (mem_ack) begin
            need_pulse(hdr_rd_dn, "no hdr_rd_dn in the mem_ack cycle");
            check_val("mem_addr", row_rd_ptr, mem_addr);
         end
         if (ack_q) check_val("dma_laddr", exp_adv, dma_laddr);
         if (rd_q) begin
            need_pulse(dma_start, "no dma_start one cycle after rd");
            check_val("table dma_len", addr_w'(row_exp_len), addr_w'(exp_len[len_w-1:0]));
            check_val("dma_len", addr_w'(exp_len[len_w-1:0]), addr_w'(dma_len));
         end else if (dma_start) begin
            need_pulse(1'b0, "dma_start pulsed with no rd before it");
         end
         if (dma_dn_q) begin
            need_pulse(transfer_dn, "no transfer_dn one cycle after dma_dn");
            exp_sys <= exp_sys + ((exp_len + 32'd3) & ~32'd3);  // Whole words
         end
         if (xfer_q) check_val("sys_wr_addr", exp_sys, sys_wr_addr);
         if (updt_q) begin
            if (!ept_updt_req) need_pulse(1'b0, "ept_updt_req fell before ept_updt_dn");
            if (ept_updt_dn) check_val("ept_wr_rd_ptr", hdr_w, ept_wr_rd_ptr);
         end
         if (updt_dn_q) need_pulse(buf_updt_dn, "no buf_updt_dn after ept_updt_dn");
      end
      fetch_q   <= get_rd_ptrs;
      hdr_q     <= hdr_rd;
      ack_q     <= mem_ack;
      rd_q      <= rd;
      dma_dn_q  <= dma_dn;
      xfer_q    <= dma_dn_q;
      updt_dn_q <= ept_updt_dn;
      lvl_q     <= updt_rd_buf;
      if (updt_rd_buf && !lvl_q)
         updt_q <= 1'b1;                    // Request due from the next cycle
      else if (ept_updt_dn)
         updt_q <= 1'b0;
      if (run_done && !reported) begin
         reported <= 1'b1;
         $display("Checks %0d, value errors %0d, pulse errors %0d",
                  n_checks, value_errs, pulse_errs);
      end
   end

   assign err_cnt = value_errs + pulse_errs;

endmodule

//--- verif/sepr_tb.sv
module sepr_tb
   import sepr_pkg::*;
();

   localparam int n_rows      = 5;
   localparam int cycle_limit = n_rows * 60 + 100;   // Each row needs well under 60

   typedef struct packed {
      logic [addr_w-1:0] start_addr;
      logic [addr_w-1:0] end_addr;
      logic [addr_w-1:0] rd_ptr;
      logic [addr_w-1:0] wr_ptr;
      logic              last_op;
      logic [addr_w-1:0] hdr;         // Header word returned by memory
      logic [addr_w-1:0] cfg;         // cfg_sys_wr_addr
      logic              wr_en;
      logic              exp_empty;
      logic [len_w-1:0]  exp_len;
      logic [3:0]        ack_dly;     // Memory ack and update done delay
      logic [3:0]        dma_dly;
   } scen_t;

   // start, end, rd_ptr, wr_ptr, last_op, header, cfg, wr_en, empty, length, delays
   scen_t scen [n_rows] = '{
      '{32'h1000, 32'h10fc, 32'h1010, 32'h1080, 1'b1, 32'h1050, 32'h8000_0000, 1'b1,
        1'b0, 20'h3c, 4'd0, 4'd0},    // Plain packet, address reload
      '{32'h2000, 32'h20fc, 32'h2040, 32'h2040, 1'b0, 32'h2063, 32'h9000_0000, 1'b0,
        1'b1, 20'h1b, 4'd0, 4'd0},    // Empty buffer, three bytes in last word
      '{32'h3000, 32'h30fc, 32'h3100, 32'h3020, 1'b1, 32'h3041, 32'h0, 1'b0,
        1'b0, 20'h3d, 4'd0, 4'd0},    // Header pointer wraps to start
      '{32'h4000, 32'h40fc, 32'h40e0, 32'h4010, 1'b1, 32'h4022, 32'h0001_0000, 1'b1,
        1'b0, 20'h3a, 4'd0, 4'd0},    // Packet wraps around buffer end
      '{32'h5000, 32'h53fc, 32'h5100, 32'h5100, 1'b1, 32'h5200, 32'h0, 1'b0,
        1'b0, 20'hfc, 4'd0, 4'd0}     // Equal pointers after a write
   };

   logic              core_clk;
   logic              uctl_rst_n;
   logic              get_rd_ptrs, wr_addr_en, hdr_rd, rd, updt_rd_buf;
   logic              mem_ack, mem_dval, dma_dn, ept_updt_dn, ept_last_op;
   logic [addr_w-1:0] mem_rd_data, cfg_sys_wr_addr;
   logic [addr_w-1:0] ept_start_addr, ept_end_addr, ept_rd_ptr, ept_wr_ptr;
   logic              rd_ptrs_rcvd, buf_empty, hdr_rd_dn, transfer_dn, buf_updt_dn;
   logic              mem_rd, dma_start, ept_req_data, ept_updt_req;
   logic [addr_w-1:0] mem_addr, dma_laddr, dma_ep_start_addr, dma_ep_end_addr;
   logic [addr_w-1:0] sys_wr_addr, ept_wr_rd_ptr;
   logic [len_w-1:0]  dma_len;
   scen_t             cur;            // Row being applied
   int                row_idx;
   int                err_cnt;
   int                cycle_cnt;
   logic              run_done;

   sepr_top i_dut (.*);

   sepr_checker i_chk (
      .*,
      .row_start(cur.start_addr), .row_end(cur.end_addr), .row_rd_ptr(cur.rd_ptr),
      .row_wr_ptr(cur.wr_ptr), .row_hdr(cur.hdr), .row_cfg(cur.cfg),
      .row_last_op(cur.last_op), .row_exp_empty(cur.exp_empty), .row_exp_len(cur.exp_len)
   );

   initial begin
      core_clk = 1'b0;
      forever #10 core_clk = ~core_clk;
   end

   // Guard against a handshake that never closes
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit) begin
         @(posedge core_clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, a DUT handshake never completed", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Command sequences, inputs change on the falling edge
   // ------------------------------------------------------------------------
   task automatic fetch_ptrs();
      {ept_start_addr, ept_end_addr} = {cur.start_addr, cur.end_addr};
      {ept_rd_ptr, ept_wr_ptr}       = {cur.rd_ptr, cur.wr_ptr};
      ept_last_op     = cur.last_op;
      cfg_sys_wr_addr = cur.cfg;
      wr_addr_en      = cur.wr_en;
      get_rd_ptrs     = 1'b1;
      @(negedge core_clk);
      get_rd_ptrs = 1'b0;
      wr_addr_en  = 1'b0;
      while (!rd_ptrs_rcvd) @(negedge core_clk);
      @(negedge core_clk);            // Back in idle
   endtask

   task automatic read_header();
      hdr_rd = 1'b1;
      @(negedge core_clk);
      hdr_rd = 1'b0;
      while (!mem_rd) @(negedge core_clk);
      repeat (cur.ack_dly) @(negedge core_clk);
      {mem_ack, mem_dval, mem_rd_data} = {1'b1, 1'b1, cur.hdr};
      @(negedge core_clk);
      {mem_ack, mem_dval, mem_rd_data} = '0;
      while (mem_rd) @(negedge core_clk);
   endtask

   task automatic run_transfer();
      rd = 1'b1;
      @(negedge core_clk);
      rd = 1'b0;
      while (!dma_start) @(negedge core_clk);
      repeat (cur.dma_dly) @(negedge core_clk);
      dma_dn = 1'b1;
      @(negedge core_clk);
      dma_dn = 1'b0;
      while (!transfer_dn) @(negedge core_clk);
      @(negedge core_clk);
   endtask

   task automatic write_back();
      updt_rd_buf = 1'b1;             // Level for the whole update
      @(negedge core_clk);
      while (!ept_updt_req) @(negedge core_clk);
      repeat (cur.ack_dly) @(negedge core_clk);
      ept_updt_dn = 1'b1;
      @(negedge core_clk);
      ept_updt_dn = 1'b0;
      while (!buf_updt_dn) @(negedge core_clk);
      updt_rd_buf = 1'b0;
      @(negedge core_clk);
   endtask

   initial begin
      void'($urandom(27306));
      uctl_rst_n = 1'b0;
      run_done   = 1'b0;
      row_idx    = 0;
      cur        = '0;
      {get_rd_ptrs, wr_addr_en, hdr_rd, rd, updt_rd_buf} = '0;
      {mem_ack, mem_dval, dma_dn, ept_updt_dn, ept_last_op} = '0;
      {mem_rd_data, cfg_sys_wr_addr, ept_start_addr, ept_end_addr} = '0;
      {ept_rd_ptr, ept_wr_ptr} = '0;
      for (int i = 0; i < n_rows; i++) begin
         scen[i].ack_dly = 4'($urandom % 6);   // 0 to 5 cycles
         scen[i].dma_dly = 4'($urandom % 6);
      end
      repeat (16) @(negedge core_clk);
      uctl_rst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         row_idx = i;
         cur     = scen[i];
         fetch_ptrs();
         read_header();
         run_transfer();
         write_back();
      end
      repeat (3) @(negedge core_clk); // Trailing checks
      run_done = 1'b1;
      @(negedge core_clk);            // Count line printed by then
      if (err_cnt == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- filelist.f
rtl/sepr_pkg.sv
rtl/sepr_ctrl_fsm.sv
rtl/sepr_ptr_regs.sv
rtl/sepr_xfer_calc.sv
rtl/sepr_top.sv
verif/sepr_checker.sv
verif/sepr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sepr testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module sepr_tb \
   -Mdir obj_dir -o sepr_sim

out=$(./obj_dir/sepr_sim)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi
